/* sources.f */
src/lcd_timing_pkg.sv
src/lcd_char_pkg.sv
src/lcd_bus_writer.sv
src/lcd_screen_sequencer.sv
src/lcd_refresh_top.sv
verif/lcd_refresh_properties.sv
verif/lcd_refresh_tb.sv

/* verif/lcd_refresh_testdata.txt */
# Columns: test name, then room, up, down, left and right reading bytes in hex
# Each line after the first is applied in a refresh gap and checked in the next frame
first_frame   31 32 33 34 35
all_zero      00 00 00 00 00
all_ones      ff ff ff ff ff
digits        39 38 37 36 35
letters       41 42 43 44 45
mixed_edges   00 ff 00 ff 7f
room_only     52 20 20 20 20
walking_bit   01 02 04 08 80

/* verif/lcd_refresh_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_refresh_tb;

  import lcd_timing_pkg::*;
  import lcd_char_pkg::*;

  localparam lcd_delay_t SETUP_CYCLES   = 25'd4;
  localparam lcd_delay_t PULSE_CYCLES   = 25'd3;
  localparam lcd_delay_t HOLD_CYCLES    = 25'd5;
  localparam lcd_delay_t REFRESH_CYCLES = 25'd40;
  localparam int         WAIT_LIMIT     = 400;              // Cycles allowed for one wait

  logic          CLK;
  logic          reset;
  nav_readings_t readings;
  lcd_pins_t     lcd;

  string         test_names[$];
  nav_readings_t test_values[$];
  lcd_write_t    expected[$];                               // Frame bytes in write order
  int            errors;
  int            test_errors;
  int            tests_run;
  int            tests_failed;
  bit            timed_out;

  lcd_refresh_top #(
    .SETUP_CYCLES   (SETUP_CYCLES),
    .PULSE_CYCLES   (PULSE_CYCLES),
    .HOLD_CYCLES    (HOLD_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) dut (
    .CLK      (CLK),
    .reset    (reset),
    .readings (readings),
    .lcd      (lcd)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;                                 // 20 ns period
  end

  // --------------------
  // Test data and expected frame
  // --------------------
  task automatic load_testdata();
    int            fd;
    string         line;
    string         name;
    lcd_byte_t     v [5];
    nav_readings_t r;
    fd = $fopen("verif/lcd_refresh_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/lcd_refresh_testdata.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;      // Comment or blank
      if ($sscanf(line, "%s %h %h %h %h %h", name, v[0], v[1], v[2], v[3], v[4]) == 6) begin
        r = '{room: v[0], up: v[1], down: v[2], left: v[3], right: v[4]};
        test_names.push_back(name);
        test_values.push_back(r);
      end
    end
    $fclose(fd);
    if (test_names.size() == 0) begin
      $display("The test data file holds no usable lines");
      errors++;
    end
  endtask

  task automatic add_byte(input logic rs, input lcd_byte_t data);
    lcd_write_t w;
    w.rs   = rs;
    w.data = data;
    expected.push_back(w);
  endtask

  task automatic add_text(input string s);
    for (int i = 0; i < s.len(); i++) begin
      add_byte(1'b1, s[i]);                                 // Characters have RS high
    end
  endtask

  task automatic build_expected(input nav_readings_t r);
    expected.delete();
    add_byte(1'b0, 8'h01);                                  // Clear
    add_byte(1'b0, 8'h38);                                  // Function set, 8 bit, 2 lines
    add_byte(1'b0, 8'h0C);                                  // Display on
    add_byte(1'b0, 8'h06);                                  // Entry mode
    add_text("ROOM:");
    add_byte(1'b1, r.room);
    add_byte(1'b0, 8'hC0);                                  // DDRAM to line two
    add_text("U:");
    add_byte(1'b1, r.up);
    add_text(" D:");
    add_byte(1'b1, r.down);
    add_text(" L:");
    add_byte(1'b1, r.left);
    add_text(" R:");
    add_byte(1'b1, r.right);
    add_text(" ");
  endtask

  // --------------------
  // Pin capture
  // --------------------
  task automatic check_rw(input string name);
    assert (lcd.rw === 1'b0) else begin
      $display("[FAIL] %s: rw expected 0 actual %b", name, lcd.rw);
      test_errors++;
    end
  endtask

  // One E pulse with the byte taken at its falling edge
  task automatic capture_write(input string name, output lcd_write_t got,
                               output int low_cycles);
    int high_cycles;
    got         = '0;
    low_cycles  = 0;
    high_cycles = 0;
    while (!timed_out && lcd.e !== 1'b1) begin
      @(negedge CLK);
      low_cycles++;
      check_rw(name);
      if (low_cycles > WAIT_LIMIT) begin
        $display("%s: timed out waiting for E to rise", name);
        timed_out = 1'b1;
        test_errors++;
      end
    end
    while (!timed_out && lcd.e === 1'b1) begin
      @(negedge CLK);
      high_cycles++;
      check_rw(name);
      if (high_cycles > WAIT_LIMIT) begin
        $display("%s: E stayed high and never fell", name);
        timed_out = 1'b1;
        test_errors++;
      end
    end
    got.rs   = lcd.rs;
    got.data = lcd.db;
    if (!timed_out) begin
      assert (high_cycles == int'(PULSE_CYCLES)) else begin
        $display("[FAIL] %s: E-high cycles expected %0d actual %0d",
                 name, PULSE_CYCLES, high_cycles);
        test_errors++;
      end
    end
  endtask

  // Whole frame against the expected list and the gap before its first byte
  task automatic check_frame(input string name, input bit check_gap, input int lead_cycles);
    lcd_write_t got;
    int         low_cycles;
    for (int i = 0; i < FRAME_STEPS; i++) begin
      if (timed_out) break;
      capture_write(name, got, low_cycles);
      if (timed_out) break;
      if (i == 0 && check_gap) begin
        assert (low_cycles + lead_cycles >= int'(REFRESH_CYCLES)) else begin
          $display("[FAIL] %s: refresh gap expected >= %0d actual %0d",
                   name, REFRESH_CYCLES, low_cycles + lead_cycles);
          test_errors++;
        end
      end
      assert (got === expected[i]) else begin
        $display("[FAIL] %s: byte %0d expected rs=%b db=%h actual rs=%b db=%h",
                 name, i, expected[i].rs, expected[i].data, got.rs, got.data);
        test_errors++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%-14s ok", name);
    end else begin
      $display("%-14s %0d check(s) wrong", name, test_errors);
      tests_failed++;
    end
    errors      += test_errors;
    test_errors  = 0;
  endtask

  // Reset during the E pulse of byte 5 and then a clean frame
  task automatic mid_frame_reset_test();
    lcd_write_t got;
    int         low_cycles;
    int         wait_cycles;
    wait_cycles = 0;
    for (int i = 0; i < 5; i++) begin
      if (!timed_out) capture_write("mid_reset", got, low_cycles);
    end
    while (!timed_out && lcd.e !== 1'b1) begin
      @(negedge CLK);
      wait_cycles++;
      if (wait_cycles > WAIT_LIMIT) begin
        $display("mid_reset: timed out waiting for E to rise");
        timed_out = 1'b1;
        test_errors++;
      end
    end
    if (!timed_out) begin
      reset = 1'b1;                                         // E still high here
      @(negedge CLK);
      assert (lcd.e === 1'b0 && lcd.rs === 1'b0 && lcd.db === 8'h00) else begin
        $display("[FAIL] mid_reset: pins expected e=0 rs=0 db=00 actual e=%b rs=%b db=%h",
                 lcd.e, lcd.rs, lcd.db);
        test_errors++;
      end
      repeat (4) @(negedge CLK);
      reset = 1'b0;
      check_frame("mid_reset", 1'b0, 0);                    // Starts again at clear
    end
    finish_test("mid_reset");
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    reset        = 1'b1;
    readings     = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    load_testdata();
    if (test_names.size() > 0) begin
      readings = test_values[0];
      repeat (5) @(negedge CLK);
      reset = 1'b0;
      for (int t = 0; t < test_names.size(); t++) begin
        if (timed_out) break;
        if (t > 0) begin
          repeat (int'(HOLD_CYCLES) + 1) @(negedge CLK);    // Past hold and into the gap
          readings = test_values[t];
        end
        build_expected(test_values[t]);
        check_frame(test_names[t], t > 0, (t > 0) ? int'(HOLD_CYCLES) + 1 : 0);
        finish_test(test_names[t]);
      end
      if (!timed_out) mid_frame_reset_test();
    end
    if (timed_out) $display("Run stopped early after a timeout");
    if (dut.u_writer.u_properties.fail_count > 0) begin
      $display("Pin protocol assertions failed %0d time(s)",
               dut.u_writer.u_properties.fail_count);
      errors += dut.u_writer.u_properties.fail_count;
    end
    $display("Tests run %0d, tests failed %0d, wrong checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : lcd_refresh_tb

`default_nettype wire

/* verif/lcd_refresh_properties.sv */
`timescale 1ns/10ps
`default_nettype none

// LCD pin protocol checks on the write engine
module lcd_refresh_properties (
  input logic                    CLK,
  input logic                    reset,
  input logic                    start,                  // Request from sequencer
  input logic                    done,                   // Last hold cycle
  input lcd_char_pkg::lcd_pins_t lcd
);

  int fail_count = 0;                                    // Failed assertion count

  // --------------------
  // Bus stability
  // --------------------
  property p_bus_stable_while_e_high;
    @(posedge CLK) disable iff (reset)
      lcd.e |=> (!lcd.e || ($stable(lcd.rs) && $stable(lcd.db)));
  endproperty

  property p_no_rise_after_start;                          // Setup phase comes first
    @(posedge CLK) disable iff (reset)
      start |=> !$rose(lcd.e);
  endproperty

  property p_done_not_during_pulse;
    @(posedge CLK) disable iff (reset)
      !(done && lcd.e);
  endproperty

  a_bus_stable: assert property (p_bus_stable_while_e_high)
    else begin
      $error("RS or DB changed while E was high");
      fail_count++;
    end
  a_setup_first: assert property (p_no_rise_after_start)
    else begin
      $error("E rose in the cycle right after start");
      fail_count++;
    end
  a_done_low: assert property (p_done_not_during_pulse)
    else begin
      $error("Done was high while E was high");
      fail_count++;
    end

endmodule : lcd_refresh_properties

bind lcd_bus_writer lcd_refresh_properties u_properties (
  .CLK   (CLK),
  .reset (reset),
  .start (start),
  .done  (done),
  .lcd   (lcd)
);

`default_nettype wire

/* src/lcd_refresh_top.sv */
`timescale 1ns/10ps
`default_nettype none

// Character-LCD refresh controller for navigation readings
module lcd_refresh_top #(
  parameter lcd_timing_pkg::lcd_delay_t SETUP_CYCLES   = lcd_timing_pkg::DEF_SETUP_CYCLES,
  parameter lcd_timing_pkg::lcd_delay_t PULSE_CYCLES   = lcd_timing_pkg::DEF_PULSE_CYCLES,
  parameter lcd_timing_pkg::lcd_delay_t HOLD_CYCLES    = lcd_timing_pkg::DEF_HOLD_CYCLES,
  parameter lcd_timing_pkg::lcd_delay_t REFRESH_CYCLES = lcd_timing_pkg::DEF_REFRESH_CYCLES
) (
  input  logic                        CLK,
  input  logic                        reset,
  input  lcd_char_pkg::nav_readings_t readings,
  output lcd_char_pkg::lcd_pins_t     lcd
);

  import lcd_char_pkg::*;

  logic       start;                                      // Sequencer to writer
  logic       done;                                       // Writer to sequencer
  lcd_write_t write;

  // --------------------
  // Frame sequencer
  // --------------------
  lcd_screen_sequencer #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_sequencer (
    .CLK      (CLK),
    .reset    (reset),
    .readings (readings),
    .done     (done),
    .start    (start),
    .write    (write)
  );

  // --------------------
  // Pin write engine
  // --------------------
  lcd_bus_writer #(
    .SETUP_CYCLES (SETUP_CYCLES),
    .PULSE_CYCLES (PULSE_CYCLES),
    .HOLD_CYCLES  (HOLD_CYCLES)
  ) u_writer (
    .CLK   (CLK),
    .reset (reset),
    .start (start),
    .write (write),
    .done  (done),
    .lcd   (lcd)
  );

endmodule : lcd_refresh_top

`default_nettype wire

/* src/lcd_screen_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

// Walks the 27 frame bytes and waits out the refresh gap
module lcd_screen_sequencer #(
  parameter lcd_timing_pkg::lcd_delay_t REFRESH_CYCLES = lcd_timing_pkg::DEF_REFRESH_CYCLES
) (
  input  logic                        CLK,
  input  logic                        reset,
  input  lcd_char_pkg::nav_readings_t readings,
  input  logic                        done,               // Writer finished a byte
  output logic                        start,              // One-cycle request
  output lcd_char_pkg::lcd_write_t    write
);

  import lcd_timing_pkg::*;
  import lcd_char_pkg::*;

  typedef enum logic [1:0] {
    SEQ_ISSUE,                                            // Send the current step
    SEQ_WAIT,                                             // Writer busy
    SEQ_REFRESH                                           // Gap before next frame
  } seq_state_t;

  seq_state_t  state;
  lcd_step_t   step;                                      // Step in flight
  lcd_step_t   step_next;
  lcd_step_t   issue_step;                                // Step selected this cycle
  logic        last_step;
  logic        issue_now;
  lcd_delay_t  gap_cnt;
  logic        start_q;
  lcd_write_t  write_q;

  // --------------------
  // Frame content
  // --------------------
  function automatic lcd_write_t frame_byte(input lcd_step_t s, input nav_readings_t r);
    lcd_write_t w;
    w.rs = !((s <= lcd_step_t'(3)) || (s == lcd_step_t'(10)));  // Instructions have RS low
    case (s)
      5'd0:    w.data = CMD_CLEAR;
      5'd1:    w.data = CMD_FUNCTION_SET;
      5'd2:    w.data = CMD_DISPLAY_ON;
      5'd3:    w.data = CMD_ENTRY_MODE;
      5'd4:    w.data = CHR_R;                            // "ROOM:"
      5'd5:    w.data = CHR_O;
      5'd6:    w.data = CHR_O;
      5'd7:    w.data = CHR_M;
      5'd8:    w.data = CHR_COLON;
      5'd9:    w.data = r.room;
      5'd10:   w.data = CMD_LINE_TWO;
      5'd11:   w.data = CHR_U;                            // "U:" up
      5'd12:   w.data = CHR_COLON;
      5'd13:   w.data = r.up;
      5'd14:   w.data = CHR_SPACE;
      5'd15:   w.data = CHR_D;                            // "D:" down
      5'd16:   w.data = CHR_COLON;
      5'd17:   w.data = r.down;
      5'd18:   w.data = CHR_SPACE;
      5'd19:   w.data = CHR_L;                            // "L:" left
      5'd20:   w.data = CHR_COLON;
      5'd21:   w.data = r.left;
      5'd22:   w.data = CHR_SPACE;
      5'd23:   w.data = CHR_R;                            // "R:" right
      5'd24:   w.data = CHR_COLON;
      5'd25:   w.data = r.right;
      5'd26:   w.data = CHR_SPACE;
      default: w.data = CHR_SPACE;                        // Unreachable steps
    endcase
    return w;
  endfunction

  // --------------------
  // Step issue
  // --------------------
  assign step_next  = step + lcd_step_t'(1);
  assign last_step  = (step == lcd_step_t'(FRAME_STEPS - 1));

  // Issue after reset or refresh, or right after done mid-frame
  assign issue_now  = (state == SEQ_ISSUE) ||
                      ((state == SEQ_WAIT) && done && !last_step);
  assign issue_step = (state == SEQ_ISSUE) ? step : step_next;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= SEQ_ISSUE;
      step    <= '0;
      gap_cnt <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= issue_now;                               // Single-cycle strobe
      case (state)
        SEQ_ISSUE: begin
          state <= SEQ_WAIT;
        end

        SEQ_WAIT: begin
          if (done) begin
            if (last_step) begin
              gap_cnt <= REFRESH_CYCLES - lcd_delay_t'(1);
              state   <= SEQ_REFRESH;
            end else begin
              step <= step_next;                          // Stay in WAIT for next byte
            end
          end
        end

        SEQ_REFRESH: begin
          if (gap_cnt == '0) begin
            step  <= '0;                                  // Restart at CMD_CLEAR
            state <= SEQ_ISSUE;
          end else begin
            gap_cnt <= gap_cnt - lcd_delay_t'(1);
          end
        end

        default: begin
          step  <= '0;
          state <= SEQ_ISSUE;
        end
      endcase
    end
  end

  // Byte picked when the step issues, readings sampled here
  always_ff @(posedge CLK) begin
    if (issue_now) begin
      write_q <= frame_byte(issue_step, readings);
    end
  end

  assign start = start_q;
  assign write = write_q;

endmodule : lcd_screen_sequencer

`default_nettype wire

/* src/lcd_bus_writer.sv */
`timescale 1ns/10ps
`default_nettype none

// Drives one byte onto the LCD pins as setup, E pulse and hold phases
module lcd_bus_writer #(
  parameter lcd_timing_pkg::lcd_delay_t SETUP_CYCLES = lcd_timing_pkg::DEF_SETUP_CYCLES,
  parameter lcd_timing_pkg::lcd_delay_t PULSE_CYCLES = lcd_timing_pkg::DEF_PULSE_CYCLES,
  parameter lcd_timing_pkg::lcd_delay_t HOLD_CYCLES  = lcd_timing_pkg::DEF_HOLD_CYCLES
) (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     start,                 // One-cycle request
  input  lcd_char_pkg::lcd_write_t write,                 // Byte and RS, taken on start
  output logic                     done,                  // Last hold cycle
  output lcd_char_pkg::lcd_pins_t  lcd
);

  import lcd_timing_pkg::*;
  import lcd_char_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,                                              // Waiting for start
    WR_SETUP,                                             // E low, RS and DB valid
    WR_PULSE,                                             // E high
    WR_HOLD                                               // E low after the falling edge
  } wr_state_t;

  wr_state_t  state;
  lcd_delay_t cnt;                                        // Cycles left in phase, minus one
  logic       cnt_zero;
  logic       rs_q;
  logic       e_q;
  lcd_byte_t  db_q;

  assign cnt_zero = (cnt == '0);

  // --------------------
  // Phase FSM
  // --------------------
  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= WR_IDLE;
      cnt   <= '0;
      rs_q  <= 1'b0;                                      // Pins quiet after reset
      db_q  <= '0;
      e_q   <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (start) begin
            rs_q  <= write.rs;                            // Capture so pins stay stable
            db_q  <= write.data;
            cnt   <= SETUP_CYCLES - lcd_delay_t'(1);
            state <= WR_SETUP;
          end
        end

        WR_SETUP: begin
          if (cnt_zero) begin
            e_q   <= 1'b1;                                // Rising edge of E
            cnt   <= PULSE_CYCLES - lcd_delay_t'(1);
            state <= WR_PULSE;
          end else begin
            cnt <= cnt - lcd_delay_t'(1);
          end
        end

        WR_PULSE: begin
          if (cnt_zero) begin
            e_q   <= 1'b0;                                // Display latches here
            cnt   <= HOLD_CYCLES - lcd_delay_t'(1);
            state <= WR_HOLD;
          end else begin
            cnt <= cnt - lcd_delay_t'(1);
          end
        end

        WR_HOLD: begin
          if (cnt_zero) begin
            state <= WR_IDLE;                             // Done is high this cycle
          end else begin
            cnt <= cnt - lcd_delay_t'(1);
          end
        end

        default: begin
          state <= WR_IDLE;
          e_q   <= 1'b0;
        end
      endcase
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign done = (state == WR_HOLD) && cnt_zero;           // Sequencer may restart next cycle

  assign lcd = '{
    rs: rs_q,
    rw: 1'b0,                                             // Write-only display
    e:  e_q,
    db: db_q
  };

endmodule : lcd_bus_writer

`default_nettype wire

/* src/lcd_char_pkg.sv */
`default_nettype none

// --------------------
// HD44780 codes and frame data types
// --------------------
package lcd_char_pkg;

  typedef logic [7:0] lcd_byte_t;                         // One DB7..DB0 byte
  typedef logic [4:0] lcd_step_t;                         // Index into the frame

  localparam int FRAME_STEPS = 27;                        // Byte writes per frame

  // Instruction codes, written with RS low
  localparam lcd_byte_t CMD_CLEAR        = 8'h01;         // Clear display, home cursor
  localparam lcd_byte_t CMD_FUNCTION_SET = 8'h38;         // 8-bit bus, 2 lines, 5x8 font
  localparam lcd_byte_t CMD_DISPLAY_ON   = 8'h0C;         // Display on, cursor off
  localparam lcd_byte_t CMD_ENTRY_MODE   = 8'h06;         // Increment address, no shift
  localparam lcd_byte_t CMD_LINE_TWO     = 8'hC0;         // DDRAM address 0x40

  // Fixed characters, written with RS high
  localparam lcd_byte_t CHR_R     = 8'h52;
  localparam lcd_byte_t CHR_O     = 8'h4F;
  localparam lcd_byte_t CHR_M     = 8'h4D;
  localparam lcd_byte_t CHR_U     = 8'h55;
  localparam lcd_byte_t CHR_D     = 8'h44;
  localparam lcd_byte_t CHR_L     = 8'h4C;
  localparam lcd_byte_t CHR_COLON = 8'h3A;
  localparam lcd_byte_t CHR_SPACE = 8'h20;

  // One byte request from sequencer to writer
  typedef struct packed {
    logic      rs;                                        // High for character data
    lcd_byte_t data;
  } lcd_write_t;

  // Display pins
  typedef struct packed {
    logic      rs;                                        // Register select
    logic      rw;                                        // Always write
    logic      e;                                         // Latch on falling edge
    lcd_byte_t db;
  } lcd_pins_t;

  // Navigation readings shown on the display
  typedef struct packed {
    lcd_byte_t room;
    lcd_byte_t up;
    lcd_byte_t down;
    lcd_byte_t left;
    lcd_byte_t right;
  } nav_readings_t;

endpackage : lcd_char_pkg

`default_nettype wire

/* src/lcd_timing_pkg.sv */
`default_nettype none

// --------------------
// Phase and refresh timing for the LCD write cycle
// --------------------
package lcd_timing_pkg;

  localparam int DELAY_W = 25;                            // Holds the refresh count at 50 MHz

  typedef logic [DELAY_W-1:0] lcd_delay_t;                // Phase down-counter value

  // Defaults at a 50 MHz clock
  localparam lcd_delay_t DEF_SETUP_CYCLES   = 25'd792000;     // About 15 ms with E low
  localparam lcd_delay_t DEF_PULSE_CYCLES   = 25'd14;         // About 250 ns E-high pulse
  localparam lcd_delay_t DEF_HOLD_CYCLES    = 25'd216480;     // About 4.1 ms after E falls
  localparam lcd_delay_t DEF_REFRESH_CYCLES = 25'd30900000;   // About 0.6 s between frames

endpackage : lcd_timing_pkg

`default_nettype wire
